// ==== testbench/memCtrl_testdata.txt ====
# group hold client cmd addr data tag expect (cmd 1-3 load b/h/w, 4-6 store b/h/w)
# steps of one group start together, hold=1 keeps arready and awready low for a while
0 0 0 6 00000010 cafef00d 01 00000000
1 0 1 3 00000010 00000000 02 cafef00d
2 0 0 6 00000020 11223344 03 00000000
3 0 2 4 00000021 000000aa 04 00000000
3 0 1 5 00000022 0000beef 05 00000000
4 0 0 3 00000020 00000000 06 beefaa44
5 0 0 6 00000030 aaaa0000 07 00000000
5 0 1 6 00000034 bbbb1111 08 00000000
5 0 2 6 00000038 cccc2222 09 00000000
6 0 2 3 00000038 00000000 0a cccc2222
6 0 0 3 00000030 00000000 0b aaaa0000
6 0 1 3 00000034 00000000 0c bbbb1111
7 1 0 3 00000010 00000000 0d cafef00d
7 1 0 3 00000020 00000000 0e beefaa44
7 1 1 6 00000040 12345678 0f 00000000
7 1 1 3 00000030 00000000 10 aaaa0000
7 1 2 6 00000044 9abcdef0 11 00000000
8 0 2 1 00000023 00000000 12 beefaa44
8 0 0 3 00000040 00000000 13 12345678
9 0 1 2 00000046 00000000 14 9abcdef0

// ==== memCtrl.f ====
+incdir+logic
logic/memCtrlPkg.sv
logic/requestArbiter.sv
logic/transferTable.sv
logic/axiIssuer.sv
logic/singleAccessMemCtrl.sv
testbench/memCtrlTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module memCtrlTb \
    -f memCtrl.f -o memCtrlSim
./obj_dir/memCtrlSim | tee sim.log
if grep -q "PASS: all tests" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== testbench/memCtrlTb.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "memCtrl_defines.svh"

module memCtrlTb
    import memCtrlPkg::*;
();

    logic clk;
    logic rst;
    ClientReq reqs [`MEMCTRL_NUM_CLIENTS];
    logic [`MEMCTRL_NUM_CLIENTS-1:0] stall;
    LoadRes loadRes;
    StoreRes storeRes;

    logic [1:0] arid, awid, rid, bid;
    logic [31:0] araddr, awaddr, rdata, wdata;
    logic [7:0] arlen, awlen;
    logic [2:0] arsize, awsize;
    logic [1:0] arburst, awburst;
    logic [0:0] arlock, awlock;
    logic [3:0] arcache, awcache, wstrb;
    logic arvalid, arready, awvalid, awready, wvalid, wready, wlast;
    logic rvalid, rready, bvalid, bready;

    // Steps read from the data file
    int nSteps;
    int stGroup [64];
    int stHold [64];
    int stClient [64];
    int stCmd [64];
    int stTag [64];
    logic [31:0] stAddr [64];
    logic [31:0] stData [64];
    logic [31:0] stExpect [64];

    int errors;
    int acceptCount;
    int respCount;
    int pendingCount;
    int cur [`MEMCTRL_NUM_CLIENTS];
    bit holdReady;
    bit timedOut;
    bit pendingTag [256];
    bit expectLoad [256];
    logic [31:0] expectWord [256];
    logic [2:0] expectSize [256];
    logic [3:0] expectStrb [256];

    // Slave memory model state
    logic [31:0] mem [256];
    logic [1:0] rIdQ [$];
    logic [31:0] rAddrQ [$];
    logic [1:0] awIdQ [$];
    logic [31:0] awAddrQ [$];
    logic [31:0] wDataQ [$];
    logic [3:0] wStrbQ [$];
    logic [1:0] bIdQ [$];
    logic [31:0] wrAddr, wrData;
    logic [3:0] wrStrb;
    logic [1:0] wrId;
    logic [2:0] arSizeById [4];
    logic [2:0] awSizeById [4];
    logic [3:0] wrStrbById [4];
    logic [2:0] rSize, bSize;
    logic [3:0] bStrb;
    bit arHeld, awHeld, wHeld;
    logic [36:0] arSnap, awSnap;
    logic [35:0] wSnap;

    singleAccessMemCtrl singleAccessMemCtrl_i (
        .clk(clk), .rst(rst), .reqs(reqs), .stall(stall),
        .loadRes(loadRes), .storeRes(storeRes),
        .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
        .arburst(arburst), .arlock(arlock), .arcache(arcache),
        .arvalid(arvalid), .arready(arready),
        .rready(rready), .rid(rid), .rdata(rdata), .rvalid(rvalid),
        .awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
        .awburst(awburst), .awlock(awlock), .awcache(awcache),
        .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bready(bready), .bid(bid), .bvalid(bvalid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic reportMismatch(input string msg);
        errors++;
        $display("FAIL at %0t: %s", $time, msg);
    endtask

    task automatic checkIdle();
        if (arvalid || awvalid || wvalid || loadRes.valid || storeRes.valid)
            reportMismatch("valid output high around reset");
    endtask

    // AXI size code of a step, loads are 1-3 and stores 4-6
    function automatic logic [2:0] accessSize(input int cmd);
        return 3'((cmd - 1) % 3);
    endfunction

    // One lane per byte of the access, starting at the low address bits
    function automatic logic [3:0] byteLanes(input int cmd, input logic [31:0] addr);
        logic [3:0] fill;
        case (accessSize(cmd))
            3'd0: fill = 4'b0001;
            3'd1: fill = 4'b0011;
            default: fill = 4'b1111;
        endcase
        return fill << addr[1:0];
    endfunction

    function automatic ClientReq makeReq(input int s);
        ClientReq r;
        r.cmd = MemCmd'(stCmd[s][2:0]);
        r.addr = stAddr[s];
        r.data = stData[s];
        r.tag = stTag[s][7:0];
        return r;
    endfunction

    function automatic int nextStep(input int c, input int from, input int last);
        for (int i = from; i <= last; i++) begin
            if (stClient[i] == c)
                return i;
        end
        return -1;
    endfunction

    task automatic driveReqs();
        for (int c = 0; c < `MEMCTRL_NUM_CLIENTS; c++) begin
            if (cur[c] >= 0)
                reqs[c] <= makeReq(cur[c]);
            else
                reqs[c].cmd <= cmdNone;
        end
    endtask

    task automatic runGroup(input int first, input int last);
        int waitCycles;
        int holdCycles;
        logic [2:0] want;
        for (int c = 0; c < `MEMCTRL_NUM_CLIENTS; c++)
            cur[c] = nextStep(c, first, last);
        for (int i = first; i <= last; i++) begin
            pendingTag[stTag[i]] = 1'b1;
            expectLoad[stTag[i]] = stCmd[i] <= 3;
            expectWord[stTag[i]] = stExpect[i];
            expectSize[stTag[i]] = accessSize(stCmd[i]);
            expectStrb[stTag[i]] = byteLanes(stCmd[i], stAddr[i]);
            pendingCount++;
        end
        holdReady = stHold[first] != 0;
        holdCycles = 0;
        waitCycles = 0;
        @(posedge clk);
        driveReqs();
        while (!timedOut && (cur[0] >= 0 || cur[1] >= 0 || cur[2] >= 0)) begin
            @(negedge clk);
            // Lowest requester wins while a slot is free
            want = '1;
            if (acceptCount - respCount < `MEMCTRL_NUM_SLOTS) begin
                for (int c = 0; c < `MEMCTRL_NUM_CLIENTS; c++) begin
                    if (cur[c] >= 0 && want == 3'b111)
                        want[c] = 1'b0;
                end
            end
            if (stall !== want)
                reportMismatch($sformatf("stall %b, expected %b", stall, want));
            for (int c = 0; c < `MEMCTRL_NUM_CLIENTS; c++) begin
                if (cur[c] >= 0 && !stall[c]) begin
                    acceptCount++;
                    cur[c] = nextStep(c, cur[c] + 1, last);
                end
            end
            if (holdReady && acceptCount - respCount == `MEMCTRL_NUM_SLOTS) begin
                holdCycles++;
                if (holdCycles > 8)
                    holdReady = 1'b0;
            end
            waitCycles++;
            if (waitCycles > 2000) begin
                $display("Timeout while waiting for requests to be accepted");
                timedOut = 1'b1;
            end else begin
                @(posedge clk);
                driveReqs();
            end
        end
        holdReady = 1'b0;
        waitCycles = 0;
        while (!timedOut && pendingCount > 0) begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > 2000) begin
                $display("Timeout while waiting for results");
                timedOut = 1'b1;
            end
        end
    endtask

    // Results are checked against the tags still outstanding
    always @(negedge clk) begin
        if (!rst && loadRes.valid) begin
            if (!pendingTag[loadRes.tag] || !expectLoad[loadRes.tag]) begin
                reportMismatch($sformatf("unexpected load result, tag %h", loadRes.tag));
            end else begin
                if (loadRes.data !== expectWord[loadRes.tag])
                    reportMismatch($sformatf("tag %h load %h, expected %h", loadRes.tag,
                        loadRes.data, expectWord[loadRes.tag]));
                if (rSize !== expectSize[loadRes.tag])
                    reportMismatch($sformatf("tag %h arsize %0d, expected %0d", loadRes.tag,
                        rSize, expectSize[loadRes.tag]));
                pendingTag[loadRes.tag] = 1'b0;
                pendingCount--;
            end
        end
        if (!rst && storeRes.valid) begin
            if (!pendingTag[storeRes.tag] || expectLoad[storeRes.tag]) begin
                reportMismatch($sformatf("unexpected store result, tag %h", storeRes.tag));
            end else begin
                if (bSize !== expectSize[storeRes.tag] || bStrb !== expectStrb[storeRes.tag])
                    reportMismatch($sformatf("tag %h awsize %0d wstrb %b, expected %0d %b",
                        storeRes.tag, bSize, bStrb, expectSize[storeRes.tag],
                        expectStrb[storeRes.tag]));
                pendingTag[storeRes.tag] = 1'b0;
                pendingCount--;
            end
        end
    end

    // AXI slave model
    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready <= 1'b0;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            arHeld = 1'b0;
            awHeld = 1'b0;
            wHeld = 1'b0;
        end else begin
            if (arHeld && {arvalid, arid, araddr, arsize} !== {1'b1, arSnap})
                reportMismatch("AR changed while stalled");
            if (awHeld && {awvalid, awid, awaddr, awsize} !== {1'b1, awSnap})
                reportMismatch("AW changed while stalled");
            if (wHeld && {wvalid, wdata, wstrb} !== {1'b1, wSnap})
                reportMismatch("W changed while stalled");
            arHeld = arvalid && !arready;
            awHeld = awvalid && !awready;
            wHeld = wvalid && !wready;
            arSnap = {arid, araddr, arsize};
            awSnap = {awid, awaddr, awsize};
            wSnap = {wdata, wstrb};

            // Single beat, fixed burst, no lock, no cache attributes
            if (arvalid && {arlen, arburst, arlock, arcache} !== {8'd0, 2'b00, 1'b0, 4'd0})
                reportMismatch("AR is not a plain single-beat request");
            if (awvalid && {awlen, awburst, awlock, awcache} !== {8'd0, 2'b00, 1'b0, 4'd0})
                reportMismatch("AW is not a plain single-beat request");
            if (wvalid && wlast !== 1'b1)
                reportMismatch("wlast low on a single-beat write");
            if (rready !== 1'b1 || bready !== 1'b1)
                reportMismatch("rready or bready not held high");

            if (arvalid && arready) begin
                rIdQ.push_back(arid);
                rAddrQ.push_back(araddr);
                arSizeById[arid] = arsize;
            end
            if (awvalid && awready) begin
                awIdQ.push_back(awid);
                awAddrQ.push_back(awaddr);
                awSizeById[awid] = awsize;
            end
            if (wvalid && wready) begin
                wDataQ.push_back(wdata);
                wStrbQ.push_back(wstrb);
            end
            if (awIdQ.size() > 0 && wDataQ.size() > 0) begin
                wrAddr = awAddrQ.pop_front();
                wrData = wDataQ.pop_front();
                wrStrb = wStrbQ.pop_front();
                wrId = awIdQ.pop_front();
                for (int b = 0; b < 4; b++) begin
                    if (wrStrb[b])
                        mem[wrAddr[9:2]][8*b +: 8] = wrData[8*b +: 8];
                end
                wrStrbById[wrId] = wrStrb;
                bIdQ.push_back(wrId);
            end

            if (rvalid) begin
                respCount++;
                rSize = arSizeById[rid];
            end
            if (bvalid) begin
                respCount++;
                bSize = awSizeById[bid];
                bStrb = wrStrbById[bid];
            end
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            if (rIdQ.size() > 0 && $urandom % 3 == 0) begin
                rvalid <= 1'b1;
                rid <= rIdQ.pop_front();
                rdata <= mem[rAddrQ.pop_front() >> 2];
            end
            if (bIdQ.size() > 0 && $urandom % 3 == 0) begin
                bvalid <= 1'b1;
                bid <= bIdQ.pop_front();
            end
            arready <= holdReady ? 1'b0 : ($urandom % 2) == 1;
            awready <= holdReady ? 1'b0 : ($urandom % 2) == 1;
            wready <= ($urandom % 2) == 1;
        end
    end

    initial begin
        int fd;
        int n;
        int i;
        int j;
        string line;
        void'($urandom(32'hd0a3));
        rst = 1'b1;
        arready = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        rvalid = 1'b0;
        bvalid = 1'b0;
        rid = '0;
        bid = '0;
        rdata = '0;
        holdReady = 1'b0;
        timedOut = 1'b0;
        errors = 0;
        acceptCount = 0;
        respCount = 0;
        pendingCount = 0;
        nSteps = 0;
        for (int c = 0; c < `MEMCTRL_NUM_CLIENTS; c++)
            reqs[c] = '0;
        for (int k = 0; k < 256; k++)
            mem[k] = {k[7:0], ~k[7:0], k[7:0] ^ 8'h5a, 8'hc3};

        fd = $fopen("testbench/memCtrl_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test data file");
            errors++;
        end else begin
            while (!$feof(fd) && nSteps < 64) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%d %d %d %d %h %h %h %h", stGroup[nSteps],
                        stHold[nSteps], stClient[nSteps], stCmd[nSteps], stAddr[nSteps],
                        stData[nSteps], stTag[nSteps], stExpect[nSteps]);
                    if (n == 8)
                        nSteps++;
                end
            end
            $fclose(fd);
        end

        for (int k = 0; k < 16; k++) begin
            @(negedge clk);
            checkIdle();
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkIdle();

        i = 0;
        while (i < nSteps && !timedOut) begin
            j = i;
            while (j + 1 < nSteps && stGroup[j + 1] == stGroup[i])
                j++;
            runGroup(i, j);
            i = j + 1;
        end

        $display("Ran %0d steps, %0d accepted, %0d errors", nSteps, acceptCount, errors);
        if (errors == 0 && !timedOut && nSteps > 0 && acceptCount == nSteps) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/singleAccessMemCtrl.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "memCtrl_defines.svh"

module singleAccessMemCtrl
    import memCtrlPkg::*;
(
    input wire clk,
    input wire rst,

    input ClientReq reqs [`MEMCTRL_NUM_CLIENTS],
    output logic [`MEMCTRL_NUM_CLIENTS-1:0] stall,
    output LoadRes loadRes,
    output StoreRes storeRes,

    output logic [`MEMCTRL_ID_WIDTH-1:0] arid,
    output logic [`MEMCTRL_ADDR_WIDTH-1:0] araddr,
    output logic [7:0] arlen,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    output logic [0:0] arlock,
    output logic [3:0] arcache,
    output logic arvalid,
    input logic arready,

    output logic rready,
    input logic [`MEMCTRL_ID_WIDTH-1:0] rid,
    input logic [`MEMCTRL_DATA_WIDTH-1:0] rdata,
    input logic rvalid,

    output logic [`MEMCTRL_ID_WIDTH-1:0] awid,
    output logic [`MEMCTRL_ADDR_WIDTH-1:0] awaddr,
    output logic [7:0] awlen,
    output logic [2:0] awsize,
    output logic [1:0] awburst,
    output logic [0:0] awlock,
    output logic [3:0] awcache,
    output logic awvalid,
    input logic awready,

    output logic [`MEMCTRL_DATA_WIDTH-1:0] wdata,
    output logic [`MEMCTRL_DATA_WIDTH/8-1:0] wstrb,
    output logic wlast,
    output logic wvalid,
    input logic wready,

    output logic bready,
    input logic [`MEMCTRL_ID_WIDTH-1:0] bid,
    input logic bvalid
);

    logic slotFree;
    logic alloc;
    SlotEntry newEntry;
    IssueReq candidate;
    logic take;

    // Single-beat, non-exclusive, device-style accesses
    assign arlen = 8'd0;
    assign awlen = 8'd0;
    assign arburst = `MEMCTRL_BURST_FIXED;
    assign awburst = `MEMCTRL_BURST_FIXED;
    assign arlock = 1'b0;
    assign awlock = 1'b0;
    assign arcache = 4'd0;
    assign awcache = 4'd0;
    assign wlast = 1'b1;

    // Results are pulses, responses can never wait
    assign rready = 1'b1;
    assign bready = 1'b1;

    requestArbiter requestArbiter_i (
        .reqs(reqs),
        .slotFree(slotFree),
        .stall(stall),
        .alloc(alloc),
        .newEntry(newEntry)
    );

    transferTable transferTable_i (
        .clk(clk),
        .rst(rst),
        .alloc(alloc),
        .newEntry(newEntry),
        .slotFree(slotFree),
        .candidate(candidate),
        .take(take),
        .rvalid(rvalid),
        .rid(rid),
        .rdata(rdata),
        .bvalid(bvalid),
        .bid(bid),
        .loadRes(loadRes),
        .storeRes(storeRes)
    );

    axiIssuer axiIssuer_i (
        .clk(clk),
        .rst(rst),
        .candidate(candidate),
        .take(take),
        .arid(arid),
        .araddr(araddr),
        .arsize(arsize),
        .arvalid(arvalid),
        .arready(arready),
        .awid(awid),
        .awaddr(awaddr),
        .awsize(awsize),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready)
    );

endmodule

`default_nettype wire

// ==== logic/axiIssuer.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "memCtrl_defines.svh"

module axiIssuer
    import memCtrlPkg::*;
(
    input wire clk,
    input wire rst,

    input IssueReq candidate,
    output logic take,

    output logic [`MEMCTRL_ID_WIDTH-1:0] arid,
    output logic [`MEMCTRL_ADDR_WIDTH-1:0] araddr,
    output logic [2:0] arsize,
    output logic arvalid,
    input logic arready,

    output logic [`MEMCTRL_ID_WIDTH-1:0] awid,
    output logic [`MEMCTRL_ADDR_WIDTH-1:0] awaddr,
    output logic [2:0] awsize,
    output logic awvalid,
    input logic awready,

    output logic [`MEMCTRL_DATA_WIDTH-1:0] wdata,
    output logic [`MEMCTRL_DATA_WIDTH/8-1:0] wstrb,
    output logic wvalid,
    input logic wready
);

    logic readEmpty;
    logic writeEmpty;
    logic takeRead;
    logic takeWrite;

    // Write side is busy until both AW and W have gone out
    assign readEmpty = !arvalid;
    assign writeEmpty = !awvalid && !wvalid;

    assign takeRead = candidate.valid && candidate.isRead && readEmpty;
    assign takeWrite = candidate.valid && !candidate.isRead && writeEmpty;
    assign take = takeRead || takeWrite;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
        end else begin
            if (takeRead) begin
                arvalid <= 1'b1;
            end else if (arready) begin
                arvalid <= 1'b0;
            end

            if (takeWrite) begin
                awvalid <= 1'b1;
                wvalid <= 1'b1;
            end else begin
                // Each channel drops on its own handshake
                if (awready) begin
                    awvalid <= 1'b0;
                end
                if (wready) begin
                    wvalid <= 1'b0;
                end
            end
        end
    end

    // Fields only load when the register is empty, so they hold under back-pressure
    always_ff @(posedge clk) begin
        if (takeRead) begin
            arid <= candidate.id;
            araddr <= candidate.addr;
            arsize <= candidate.size;
        end
        if (takeWrite) begin
            awid <= candidate.id;
            awaddr <= candidate.addr;
            awsize <= candidate.size;
            wdata <= candidate.data;
            wstrb <= candidate.strobe;
        end
    end

    arHeld: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR request changed while stalled");

endmodule

`default_nettype wire

// ==== logic/transferTable.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "memCtrl_defines.svh"

module transferTable
    import memCtrlPkg::*;
(
    input wire clk,
    input wire rst,

    input logic alloc,
    input SlotEntry newEntry,
    output logic slotFree,

    output IssueReq candidate,
    input logic take,

    input logic rvalid,
    input logic [`MEMCTRL_ID_WIDTH-1:0] rid,
    input logic [`MEMCTRL_DATA_WIDTH-1:0] rdata,
    input logic bvalid,
    input logic [`MEMCTRL_ID_WIDTH-1:0] bid,

    output LoadRes loadRes,
    output StoreRes storeRes
);

    logic [`MEMCTRL_NUM_SLOTS-1:0] slotValid;
    logic [`MEMCTRL_NUM_SLOTS-1:0] needIssue;
    SlotEntry slots [`MEMCTRL_NUM_SLOTS];

    logic [`MEMCTRL_ID_WIDTH-1:0] freeIdx;

    // Lowest free slot
    always_comb begin
        freeIdx = '0;
        slotFree = 1'b0;
        for (int i = 0; i < `MEMCTRL_NUM_SLOTS; i++) begin
            if (!slotFree && !slotValid[i]) begin
                slotFree = 1'b1;
                freeIdx = i[`MEMCTRL_ID_WIDTH-1:0];
            end
        end
    end

    // Oldest-by-index pending slot, holds back the ones above it
    always_comb begin
        candidate = '0;
        for (int i = 0; i < `MEMCTRL_NUM_SLOTS; i++) begin
            if (!candidate.valid && slotValid[i] && needIssue[i]) begin
                candidate.valid = 1'b1;
                candidate.id = i[`MEMCTRL_ID_WIDTH-1:0];
                candidate.isRead = slots[i].isRead;
                candidate.addr = slots[i].addr;
                candidate.size = slots[i].size;
                candidate.strobe = slots[i].strobe;
                candidate.data = slots[i].data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            slots[freeIdx] <= newEntry;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slotValid <= '0;
            needIssue <= '0;
        end else begin
            if (alloc) begin
                slotValid[freeIdx] <= 1'b1;
                needIssue[freeIdx] <= 1'b1;
            end
            if (take) begin
                needIssue[candidate.id] <= 1'b0;
            end
            // R and B are always accepted, the ID is the slot number
            if (rvalid) begin
                slotValid[rid] <= 1'b0;
            end
            if (bvalid) begin
                slotValid[bid] <= 1'b0;
            end
        end
    end

    // One-cycle result pulses back to the clients
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loadRes.valid <= 1'b0;
            storeRes.valid <= 1'b0;
        end else begin
            loadRes.valid <= rvalid;
            storeRes.valid <= bvalid;
            if (rvalid) begin
                loadRes.tag <= slots[rid].tag;
                loadRes.data <= rdata;
            end
            if (bvalid) begin
                storeRes.tag <= slots[bid].tag;
            end
        end
    end

    allocHasRoom: assert property (@(posedge clk) disable iff (rst)
        alloc |-> slotFree)
        else $error("Allocation into a full table");

    readIdLive: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> slotValid[rid])
        else $error("Read response for idle slot %0d", rid);

    writeIdLive: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> slotValid[bid])
        else $error("Write response for idle slot %0d", bid);

endmodule

`default_nettype wire

// ==== logic/requestArbiter.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "memCtrl_defines.svh"

module requestArbiter
    import memCtrlPkg::*;
(
    input ClientReq reqs [`MEMCTRL_NUM_CLIENTS],
    input logic slotFree,
    output logic [`MEMCTRL_NUM_CLIENTS-1:0] stall,
    output logic alloc,
    output SlotEntry newEntry
);

    ClientReq sel;
    logic [`MEMCTRL_DATA_WIDTH/8-1:0] baseStrobe;

    // Lowest-numbered requester wins, nobody gets in while the table is full
    always_comb begin
        stall = '1;
        alloc = 1'b0;
        sel = reqs[0];
        for (int i = 0; i < `MEMCTRL_NUM_CLIENTS; i++) begin
            if (!alloc && slotFree && reqs[i].cmd != cmdNone) begin
                alloc = 1'b1;
                sel = reqs[i];
                stall[i] = 1'b0;
            end
        end
    end

    always_comb begin
        case (sel.cmd)
            cmdLoadByte, cmdStoreByte: begin
                newEntry.size = 3'd0;
                baseStrobe = 4'b0001;
            end
            cmdLoadHalf, cmdStoreHalf: begin
                newEntry.size = 3'd1;
                baseStrobe = 4'b0011;
            end
            default: begin
                newEntry.size = 3'd2;
                baseStrobe = 4'b1111;
            end
        endcase
        newEntry.isRead = sel.cmd inside {cmdLoadByte, cmdLoadHalf, cmdLoadWord};
        newEntry.addr = sel.addr;
        newEntry.tag = sel.tag;
        // Move store bytes into the lanes picked by the low address bits
        newEntry.strobe = baseStrobe << sel.addr[1:0];
        newEntry.data = sel.data << {sel.addr[1:0], 3'b000};

        if (alloc) begin
            assert ((newEntry.size != 3'd1 || !sel.addr[0])
                    && (newEntry.size != 3'd2 || sel.addr[1:0] == 2'b00))
                else $error("Misaligned access accepted at %h", sel.addr);
        end
    end

endmodule

`default_nettype wire

// ==== logic/memCtrlPkg.sv ====
`default_nettype none

`include "memCtrl_defines.svh"

package memCtrlPkg;

    typedef enum logic [2:0] {
        cmdNone,
        cmdLoadByte,
        cmdLoadHalf,
        cmdLoadWord,
        cmdStoreByte,
        cmdStoreHalf,
        cmdStoreWord
    } MemCmd;

    // Store value sits in the low bits of data
    typedef struct packed {
        MemCmd cmd;
        logic [`MEMCTRL_ADDR_WIDTH-1:0] addr;
        logic [`MEMCTRL_DATA_WIDTH-1:0] data;
        logic [`MEMCTRL_TAG_WIDTH-1:0] tag;
    } ClientReq;

    // Decoded transfer, data already placed in its byte lanes
    typedef struct packed {
        logic isRead;
        logic [`MEMCTRL_ADDR_WIDTH-1:0] addr;
        logic [2:0] size;
        logic [`MEMCTRL_DATA_WIDTH/8-1:0] strobe;
        logic [`MEMCTRL_DATA_WIDTH-1:0] data;
        logic [`MEMCTRL_TAG_WIDTH-1:0] tag;
    } SlotEntry;

    typedef struct packed {
        logic valid;
        logic [`MEMCTRL_ID_WIDTH-1:0] id;
        logic isRead;
        logic [`MEMCTRL_ADDR_WIDTH-1:0] addr;
        logic [2:0] size;
        logic [`MEMCTRL_DATA_WIDTH/8-1:0] strobe;
        logic [`MEMCTRL_DATA_WIDTH-1:0] data;
    } IssueReq;

    typedef struct packed {
        logic valid;
        logic [`MEMCTRL_TAG_WIDTH-1:0] tag;
        logic [`MEMCTRL_DATA_WIDTH-1:0] data;
    } LoadRes;

    typedef struct packed {
        logic valid;
        logic [`MEMCTRL_TAG_WIDTH-1:0] tag;
    } StoreRes;

endpackage

`default_nettype wire

// ==== logic/memCtrl_defines.svh ====
`ifndef MEMCTRL_DEFINES_SVH
`define MEMCTRL_DEFINES_SVH

// AXI port geometry
`define MEMCTRL_ADDR_WIDTH 32
`define MEMCTRL_DATA_WIDTH 32
`define MEMCTRL_ID_WIDTH 2

// One AXI ID per transfer slot
`define MEMCTRL_NUM_SLOTS 4

// Client side
`define MEMCTRL_NUM_CLIENTS 3
`define MEMCTRL_TAG_WIDTH 8

// Single-beat accesses only
`define MEMCTRL_BURST_FIXED 2'b00

`endif
